// ==== logic/exStage_macros.svh ====
// Shared widths, register IDs and trap codes for the execute stage, included by package and RTL
`ifndef EX_STAGE_MACROS_SVH
`define EX_STAGE_MACROS_SVH

// Datapath widths
`define EX_DATA_W 64
`define EX_ADDR_W 48

// Null destination IDs
`define EX_GPR_NONE 6'h3F // No general-register write
`define EX_CR_NONE 5'h1F // No control-register write

// Control register that holds the program counter
`define EX_CR_PC 5'h00

// Trap codes
`define EX_TRAP_RTE 16'hFF00 // Return from exception
`define EX_TRAP_TRAPA_BASE 12'hC08 // Upper bits of a TRAPA code
`define EX_TRAP_SYSE_TAG 4'hE // Upper nibble of a SYSE code

`endif

// ==== logic/exStagePkg.sv ====
// Types shared across the execute stage; modules pull them in by a wildcard import
`include "exStage_macros.svh"

package exStagePkg;

	// Condition code carried by every micro-op
	typedef enum logic [1:0] {
		COND_AL = 2'd0, // Always
		COND_NV = 2'd1, // Never
		COND_CT = 2'd2, // If T set
		COND_CF = 2'd3 // If T clear
	} exCond_t;

	typedef enum logic [5:0] {
		UCMD_NOP = 6'h00,
		UCMD_INVOP = 6'h01,
		UCMD_LEA_MR = 6'h02,
		UCMD_MOV_RM = 6'h03, // Store
		UCMD_MOV_MR = 6'h04, // Load
		UCMD_MOV_IR = 6'h05,
		UCMD_MOV_RC = 6'h06,
		UCMD_BRA = 6'h07,
		UCMD_BSR = 6'h08,
		UCMD_JMP = 6'h09,
		UCMD_JSR = 6'h0A,
		UCMD_OP_FLAG = 6'h0B,
		UCMD_OP_SYS = 6'h0C
	} exUCmd_t;

	// Sub-operation in ixt[5:0] for the FLAG and SYS commands
	typedef enum logic [5:0] {
		SUB_CLRT = 6'h00,
		SUB_SETT = 6'h01,
		SUB_NOTT = 6'h02,
		SUB_CLRS = 6'h03,
		SUB_SETS = 6'h04,
		SUB_NOTS = 6'h05,
		SUB_MOVT = 6'h06,
		SUB_MOVNT = 6'h07,
		SUB_NOP = 6'h10, // SYS group starts here
		SUB_BREAK = 6'h11,
		SUB_TRAPA = 6'h12,
		SUB_RTE = 6'h13,
		SUB_SYSE = 6'h14
	} exSub_t;

	typedef enum logic [1:0] {
		MEM_NONE = 2'd0,
		MEM_LOAD = 2'd1,
		MEM_STORE = 2'd2
	} exMemKind_t;

	typedef struct packed {
		exCond_t cond;
		exUCmd_t cmd;
		logic [7:0] ixt; // [5:4] size/scale, [3:0] MOV_IR form
		logic [5:0] idRm;
		logic [`EX_DATA_W-1:0] valRs;
		logic [`EX_DATA_W-1:0] valRt;
		logic [`EX_DATA_W-1:0] valRm;
		logic [`EX_ADDR_W-1:0] pc;
	} exOp_t;

	typedef struct packed {
		logic [`EX_DATA_W-1:0] sr; // Bit 0 is T, bit 1 is S
		logic [`EX_ADDR_W-1:0] lr;
		logic [`EX_DATA_W-1:0] dlr;
	} exCtrl_t;

	// Control-register writebacks keep id[5] at zero
	typedef struct packed {
		logic [5:0] id;
		logic [`EX_DATA_W-1:0] val;
	} exRegWb_t;

	typedef struct packed {
		exMemKind_t kind;
		logic [1:0] size;
		logic [`EX_ADDR_W-1:0] addr;
		logic [`EX_DATA_W-1:0] data;
	} exMemReq_t;

	typedef struct packed {
		exRegWb_t gpr;
		exRegWb_t cr;
		logic [5:0] heldId; // Load destination still pending
		logic [`EX_DATA_W-1:0] srOut;
		logic [`EX_ADDR_W-1:0] lrOut;
		logic [15:0] trapCode;
		exMemReq_t memReq;
		logic fault;
	} exResult_t;

endpackage

// ==== logic/exOpGate.sv ====
// Input register of the execute stage that applies predication and flush to a strobed op
module exOpGate import exStagePkg::*; (
	input logic clock,
	input logic rstN,
	input logic opValid,
	input logic opFlush,
	input exOp_t op,
	input exCtrl_t ctrl,
	output logic gatedValid,
	output exOp_t gated,
	output exCtrl_t gatedCtrl
);

	logic condHit;
	logic opEnable;
	exOp_t opNext;

	// Predication uses T as seen at capture
	always_comb begin
		case (op.cond)
			COND_AL: condHit = 1'b1;
			COND_NV: condHit = 1'b0;
			COND_CT: condHit = ctrl.sr[0];
			COND_CF: condHit = !ctrl.sr[0];
			default: condHit = 1'b0;
		endcase
		opEnable = condHit && !opFlush; // Flush always wins

		opNext = op;
		opNext.cond = COND_AL; // Already resolved
		if (!opEnable) begin
			opNext.cmd = UCMD_NOP; // Still produces a result strobe
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			gatedValid <= 1'b0;
		end else begin
			gatedValid <= opValid;
		end
	end

	always_ff @(posedge clock) begin
		if (opValid) begin
			gated <= opNext;
			gatedCtrl <= ctrl;
		end
	end

endmodule

// ==== logic/exAddrGen.sv ====
// Scaled-index adder used for load/store addresses, LEA and PC-relative branch targets
`include "exStage_macros.svh"

module exAddrGen (
	input logic [`EX_ADDR_W-1:0] base,
	input logic [`EX_ADDR_W-1:0] index,
	input logic [1:0] scale, // Element size as log2 bytes
	output logic [`EX_ADDR_W-1:0] agAddr
);

	logic [`EX_ADDR_W-1:0] scaledIndex;

	always_comb begin
		case (scale)
			2'd0: scaledIndex = index;
			2'd1: scaledIndex = {index[`EX_ADDR_W-2:0], 1'b0};
			2'd2: scaledIndex = {index[`EX_ADDR_W-3:0], 2'b00};
			default: scaledIndex = {index[`EX_ADDR_W-4:0], 3'b000};
		endcase
	end

	// Address wraps at the top bit
	assign agAddr = base + scaledIndex;

endmodule

// ==== logic/exOpExec.sv ====
// Combinational decode of the execute stage into writebacks, status, traps and memory request
`include "exStage_macros.svh"

module exOpExec import exStagePkg::*; (
	input logic gatedValid,
	input exOp_t gated,
	input exCtrl_t gatedCtrl,
	input logic [`EX_ADDR_W-1:0] agAddr,
	output logic nextValid,
	output exResult_t nextRes
);

	exSub_t sub;
	logic tBit;
	logic doBra;
	logic [`EX_ADDR_W-1:0] braTarget;

	assign nextValid = gatedValid;
	assign sub = exSub_t'(gated.ixt[5:0]);
	assign tBit = gatedCtrl.sr[0];

	always_comb begin
		nextRes.gpr.id = `EX_GPR_NONE;
		nextRes.gpr.val = gated.valRt;
		nextRes.cr.id = {1'b0, `EX_CR_NONE};
		nextRes.cr.val = gated.valRs;
		nextRes.heldId = `EX_GPR_NONE;
		nextRes.srOut = gatedCtrl.sr;
		nextRes.lrOut = gatedCtrl.lr;
		nextRes.trapCode = 16'h0000;
		nextRes.memReq.kind = MEM_NONE;
		nextRes.memReq.size = gated.ixt[5:4];
		nextRes.memReq.addr = agAddr;
		nextRes.memReq.data = gated.valRm; // Store data
		nextRes.fault = 1'b0;
		doBra = 1'b0;
		braTarget = agAddr; // PC-relative by default

		case (gated.cmd)
			UCMD_NOP: begin
			end
			UCMD_INVOP: nextRes.fault = 1'b1;
			UCMD_LEA_MR: begin
				nextRes.gpr.id = gated.idRm;
				nextRes.gpr.val = {{(`EX_DATA_W-`EX_ADDR_W){1'b0}}, agAddr};
			end
			UCMD_MOV_RM: nextRes.memReq.kind = MEM_STORE;
			UCMD_MOV_MR: begin
				nextRes.memReq.kind = MEM_LOAD;
				nextRes.heldId = gated.idRm; // Filled in by the load later
			end
			UCMD_MOV_IR: begin
				nextRes.gpr.id = gated.idRm;
				case (gated.ixt[3:0])
					4'h1: nextRes.gpr.val = {gated.valRs[55:0], gated.valRt[7:0]};
					4'h2: nextRes.gpr.val = {gated.valRs[47:0], gated.valRt[15:0]};
					4'h3: nextRes.gpr.val = {gated.valRs[31:0], gated.valRt[31:0]};
					default: nextRes.gpr.val = gated.valRt; // Plain load of constant
				endcase
			end
			UCMD_MOV_RC: nextRes.cr.id = {1'b0, gated.idRm[4:0]};
			UCMD_BRA: doBra = 1'b1;
			UCMD_BSR: begin
				doBra = 1'b1;
				nextRes.lrOut = gated.pc;
			end
			UCMD_JMP: begin
				doBra = 1'b1;
				braTarget = gated.valRs[`EX_ADDR_W-1:0];
			end
			UCMD_JSR: begin
				doBra = 1'b1;
				braTarget = gated.valRs[`EX_ADDR_W-1:0];
				nextRes.lrOut = gated.pc;
			end
			UCMD_OP_FLAG: begin
				case (sub)
					SUB_CLRT: nextRes.srOut[0] = 1'b0;
					SUB_SETT: nextRes.srOut[0] = 1'b1;
					SUB_NOTT: nextRes.srOut[0] = !tBit;
					SUB_CLRS: nextRes.srOut[1] = 1'b0;
					SUB_SETS: nextRes.srOut[1] = 1'b1;
					SUB_NOTS: nextRes.srOut[1] = !gatedCtrl.sr[1];
					SUB_MOVT: begin
						nextRes.gpr.id = gated.idRm;
						nextRes.gpr.val = {{(`EX_DATA_W-1){1'b0}}, tBit};
					end
					SUB_MOVNT: begin
						nextRes.gpr.id = gated.idRm;
						nextRes.gpr.val = {{(`EX_DATA_W-1){1'b0}}, !tBit};
					end
					default: nextRes.fault = 1'b1; // Unhandled flag op
				endcase
			end
			UCMD_OP_SYS: begin
				case (sub)
					SUB_NOP: begin
					end
					SUB_BREAK: nextRes.fault = 1'b1;
					SUB_TRAPA: nextRes.trapCode = {`EX_TRAP_TRAPA_BASE, gated.idRm[3:0]};
					SUB_RTE: nextRes.trapCode = `EX_TRAP_RTE;
					SUB_SYSE: nextRes.trapCode = {`EX_TRAP_SYSE_TAG, gatedCtrl.dlr[11:0]};
					default: nextRes.fault = 1'b1;
				endcase
			end
			default: nextRes.fault = 1'b1; // Unknown command
		endcase

		// Branches go out as a PC write
		if (doBra) begin
			nextRes.cr.id = {1'b0, `EX_CR_PC};
			nextRes.cr.val = {{(`EX_DATA_W-`EX_ADDR_W){1'b0}}, braTarget};
		end
	end

endmodule

// ==== logic/exResultStage.sv ====
// Output register of the execute stage that holds the sticky fault and reports stall
`include "exStage_macros.svh"

module exResultStage import exStagePkg::*; (
	input logic clock,
	input logic rstN,
	input logic nextValid,
	input exResult_t nextRes,
	input logic memBusy,
	output logic resValid,
	output exResult_t res,
	output logic stall,
	output logic haltFault
);

	exResult_t resData; // Values and addresses
	logic [5:0] gprId;
	logic [5:0] crId;
	logic [5:0] heldId;
	exMemKind_t memKind;
	logic fault;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			resValid <= 1'b0;
			gprId <= `EX_GPR_NONE;
			crId <= {1'b0, `EX_CR_NONE};
			heldId <= `EX_GPR_NONE;
			memKind <= MEM_NONE;
			fault <= 1'b0;
			haltFault <= 1'b0;
		end else begin
			resValid <= nextValid;
			if (nextValid) begin
				gprId <= nextRes.gpr.id;
				crId <= nextRes.cr.id;
				heldId <= nextRes.heldId;
				memKind <= nextRes.memReq.kind;
				fault <= nextRes.fault;
			end
			if (nextValid && nextRes.fault) begin
				haltFault <= 1'b1; // Sticky until reset
			end
		end
	end

	always_ff @(posedge clock) begin
		if (nextValid) begin
			resData <= nextRes;
		end
	end

	always_comb begin
		res = resData;
		res.gpr.id = gprId;
		res.cr.id = crId;
		res.heldId = heldId;
		res.memReq.kind = memKind;
		res.fault = fault;
	end

	// Reported upward only as the stage keeps going
	assign stall = resValid && (memKind != MEM_NONE) && memBusy;

endmodule

// ==== logic/exStageTop.sv ====
// Top level of the execute stage, wiring input gate, address generator, decoder and result register
`include "exStage_macros.svh"

module exStageTop import exStagePkg::*; (
	input logic clock,
	input logic rstN,
	input logic opValid,
	input exOp_t op,
	input exCtrl_t ctrl,
	input logic opFlush,
	input logic memBusy,
	output logic resValid,
	output exResult_t res,
	output logic stall,
	output logic haltFault
);

	logic gatedValid;
	exOp_t gated;
	exCtrl_t gatedCtrl;
	logic [`EX_ADDR_W-1:0] agAddr;
	logic nextValid;
	exResult_t nextRes;

	exOpGate exOpGate_inst (
		.clock(clock),
		.rstN(rstN),
		.opValid(opValid),
		.opFlush(opFlush),
		.op(op),
		.ctrl(ctrl),
		.gatedValid(gatedValid),
		.gated(gated),
		.gatedCtrl(gatedCtrl)
	);

	// Base is Rs (PC for relative branches), index is Rt
	exAddrGen exAddrGen_inst (
		.base(gated.valRs[`EX_ADDR_W-1:0]),
		.index(gated.valRt[`EX_ADDR_W-1:0]),
		.scale(gated.ixt[5:4]),
		.agAddr(agAddr)
	);

	exOpExec exOpExec_inst (
		.gatedValid(gatedValid),
		.gated(gated),
		.gatedCtrl(gatedCtrl),
		.agAddr(agAddr),
		.nextValid(nextValid),
		.nextRes(nextRes)
	);

	exResultStage exResultStage_inst (
		.clock(clock),
		.rstN(rstN),
		.nextValid(nextValid),
		.nextRes(nextRes),
		.memBusy(memBusy),
		.resValid(resValid),
		.res(res),
		.stall(stall),
		.haltFault(haltFault)
	);

endmodule

// ==== testbench/exStageChecks.svh ====
// Typed compare tasks and reference helpers for the execute-stage testbench, included in its module
`ifndef EX_STAGE_CHECKS_SVH
`define EX_STAGE_CHECKS_SVH

int errorCount = 0;
int checkCount = 0;

// Value only matters when a write is expected
task automatic checkRegWb(input string name, input exRegWb_t got, input exRegWb_t want,
		input logic [5:0] nullId);
	checkCount++;
	if (got.id !== want.id || (want.id != nullId && got.val !== want.val)) begin
		errorCount++;
		$display("[ERROR] %0t %s: got id=%h val=%h, expected id=%h val=%h",
			$time, name, got.id, got.val, want.id, want.val);
	end
endtask

task automatic checkMemReq(input string name, input exMemReq_t got, input exMemReq_t want);
	logic bad;
	checkCount++;
	bad = got.kind !== want.kind;
	if (want.kind != MEM_NONE) begin
		bad = bad || got.size !== want.size || got.addr !== want.addr;
	end
	if (want.kind == MEM_STORE) begin
		bad = bad || got.data !== want.data; // Only stores carry data
	end
	if (bad) begin
		errorCount++;
		$write("[ERROR] %0t %s: got kind=%0d size=%0d addr=%h data=%h, ",
			$time, name, got.kind, got.size, got.addr, got.data);
		$display("expected kind=%0d size=%0d addr=%h data=%h",
			want.kind, want.size, want.addr, want.data);
	end
endtask

task automatic checkWord(input string name, input logic [63:0] got, input logic [63:0] want);
	checkCount++;
	if (got !== want) begin
		errorCount++;
		$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
	end
endtask

task automatic checkBit(input string name, input logic got, input logic want);
	checkCount++;
	if (got !== want) begin
		errorCount++;
		$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, want);
	end
endtask

// Base plus index times element size within the address width
function automatic logic [`EX_ADDR_W-1:0] scaledAddr(input logic [`EX_ADDR_W-1:0] base,
		input logic [`EX_ADDR_W-1:0] index, input logic [1:0] scale);
	logic [`EX_ADDR_W+3:0] wide;
	wide = {4'b0, base} + ({4'b0, index} << scale);
	return wide[`EX_ADDR_W-1:0];
endfunction

// What a NOP leaves behind for the given control registers
function automatic exResult_t defaultResult(input exCtrl_t c);
	exResult_t e;
	e = '0;
	e.gpr.id = `EX_GPR_NONE;
	e.cr.id = {1'b0, `EX_CR_NONE};
	e.heldId = `EX_GPR_NONE;
	e.srOut = c.sr;
	e.lrOut = c.lr;
	e.memReq.kind = MEM_NONE;
	return e;
endfunction

`endif

// ==== testbench/exStageTb.sv ====
// Directed testbench for the execute stage, used as simulation top around the DUT and its checks
`include "exStage_macros.svh"

module exStageTb import exStagePkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLOCK_PERIOD = 40;
	localparam int OP_COUNT = 64; // Upper bound over all tests
	localparam int WATCHDOG_CYCLES = OP_COUNT * 3 + 2 * 4 + 40;

	logic clock;
	logic rstN;
	logic opValid;
	exOp_t op;
	exCtrl_t ctrl;
	logic opFlush;
	logic memBusy;
	logic resValid;
	exResult_t res;
	logic stall;
	logic haltFault;

	exOp_t curOp;
	exCtrl_t curCtrl;
	exResult_t expRes; // Expected response to curOp
	logic [31:0] rngState = 32'hf283_be74;

	`include "exStageChecks.svh"

	exStageTop exStageTop_inst (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = !clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Timeout after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic logic [63:0] random64();
		logic [31:0] hi;
		hi = nextRandom();
		return {hi, nextRandom()};
	endfunction

	// Random operands under AL with a NOP as the starting expectation
	task automatic prepareOp(input exUCmd_t cmd, input logic [7:0] ixt);
		logic [63:0] r;
		r = random64();
		curOp.cond = COND_AL;
		curOp.cmd = cmd;
		curOp.ixt = ixt;
		curOp.idRm = r[5:0];
		curOp.pc = r[63:16];
		curOp.valRs = random64();
		curOp.valRt = random64();
		curOp.valRm = random64();
		curCtrl.sr = random64();
		curCtrl.dlr = random64();
		r = random64();
		curCtrl.lr = r[47:0];
		expRes = defaultResult(curCtrl);
	endtask

	task automatic runOp(input logic flush, input logic busy);
		int waited;
		op = curOp;
		ctrl = curCtrl;
		opFlush = flush;
		memBusy = busy;
		opValid = 1'b1;
		@(posedge clock);
		#2;
		opValid = 1'b0;
		opFlush = 1'b0;
		waited = 1;
		while (!resValid && waited < 4) begin
			@(posedge clock);
			#2;
			waited++;
		end
		if (!resValid) begin
			errorCount++;
			$display("No result strobe at %0t for command %s", $time, curOp.cmd.name());
		end else begin
			if (waited != 2) begin
				errorCount++;
				$display("Result strobe came %0d cycles after the op instead of 2", waited);
			end
			checkRegWb("res.gpr", res.gpr, expRes.gpr, `EX_GPR_NONE);
			checkRegWb("res.cr", res.cr, expRes.cr, {1'b0, `EX_CR_NONE});
			checkWord("res.heldId", {58'b0, res.heldId}, {58'b0, expRes.heldId});
			checkWord("res.srOut", res.srOut, expRes.srOut);
			checkWord("res.lrOut", {16'b0, res.lrOut}, {16'b0, expRes.lrOut});
			checkWord("res.trapCode", {48'b0, res.trapCode}, {48'b0, expRes.trapCode});
			checkMemReq("res.memReq", res.memReq, expRes.memReq);
			checkBit("res.fault", res.fault, expRes.fault);
			checkBit("stall", stall, busy && (expRes.memReq.kind != MEM_NONE));
		end
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		repeat (4) @(posedge clock);
		#2;
		rstN = 1'b1;
		checkBit("resValid", resValid, 1'b0);
		checkBit("haltFault", haltFault, 1'b0);
		checkWord("res.gpr.id", {58'b0, res.gpr.id}, {58'b0, `EX_GPR_NONE});
		checkWord("res.cr.id", {58'b0, res.cr.id}, {59'b0, `EX_CR_NONE});
		checkMemReq("res.memReq", res.memReq, '0);
	endtask

	task automatic testRegMoves();
		for (int form = 0; form < 4; form++) begin
			prepareOp(UCMD_MOV_IR, {4'h0, 4'(form)});
			expRes.gpr.id = curOp.idRm;
			case (form)
				0: expRes.gpr.val = curOp.valRt;
				1: expRes.gpr.val = (curOp.valRs << 8) | (curOp.valRt & 64'hFF);
				2: expRes.gpr.val = (curOp.valRs << 16) | (curOp.valRt & 64'hFFFF);
				default: expRes.gpr.val = (curOp.valRs << 32) | (curOp.valRt & 64'hFFFF_FFFF);
			endcase
			runOp(1'b0, 1'b0);
		end
		prepareOp(UCMD_MOV_RC, 8'h00);
		expRes.cr.id = {1'b0, curOp.idRm[4:0]};
		expRes.cr.val = curOp.valRs;
		runOp(1'b0, 1'b0);
		for (int inv = 0; inv < 2; inv++) begin
			prepareOp(UCMD_OP_FLAG, {2'b00, (inv == 1) ? SUB_MOVNT : SUB_MOVT});
			expRes.gpr.id = curOp.idRm;
			expRes.gpr.val = {63'b0, curCtrl.sr[0] ^ (inv == 1)};
			runOp(1'b0, 1'b0);
		end
	endtask

	task automatic testPredication();
		logic enable;
		for (int ci = 0; ci < 4; ci++) begin
			for (int t = 0; t < 2; t++) begin
				for (int f = 0; f < 2; f++) begin
					prepareOp(UCMD_MOV_IR, 8'h00);
					curOp.cond = exCond_t'(2'(ci));
					curCtrl.sr[0] = (t == 1);
					expRes = defaultResult(curCtrl);
					enable = curOp.cond == COND_AL;
					enable = enable || (curOp.cond == COND_CT && t == 1);
					enable = enable || (curOp.cond == COND_CF && t == 0);
					if (enable && f == 0) begin
						expRes.gpr.id = curOp.idRm;
						expRes.gpr.val = curOp.valRt;
					end
					runOp(f == 1, 1'b0);
				end
			end
		end
	endtask

	task automatic testMemory();
		exUCmd_t memCmds[3] = '{UCMD_LEA_MR, UCMD_MOV_MR, UCMD_MOV_RM};
		logic [`EX_ADDR_W-1:0] addr;
		logic [31:0] r;
		for (int i = 0; i < 9; i++) begin
			r = nextRandom();
			prepareOp(memCmds[i % 3], {2'b00, r[9:8], 4'h0});
			addr = scaledAddr(curOp.valRs[`EX_ADDR_W-1:0], curOp.valRt[`EX_ADDR_W-1:0], r[9:8]);
			if (curOp.cmd == UCMD_LEA_MR) begin
				expRes.gpr.id = curOp.idRm;
				expRes.gpr.val = {16'b0, addr};
			end else begin
				expRes.memReq.kind = (curOp.cmd == UCMD_MOV_MR) ? MEM_LOAD : MEM_STORE;
				expRes.memReq.size = r[9:8];
				expRes.memReq.addr = addr;
				expRes.memReq.data = curOp.valRm;
				if (curOp.cmd == UCMD_MOV_MR) begin
					expRes.heldId = curOp.idRm;
				end
			end
			runOp(1'b0, i % 2 == 1); // Loads and stores each see busy and idle memory
		end
	endtask

	task automatic testBranches();
		exUCmd_t branchCmds[4] = '{UCMD_BRA, UCMD_BSR, UCMD_JMP, UCMD_JSR};
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = nextRandom();
			prepareOp(branchCmds[i % 4], {2'b00, r[5:4], 4'h0});
			expRes.cr.id = {1'b0, `EX_CR_PC};
			if (curOp.cmd == UCMD_BRA || curOp.cmd == UCMD_BSR) begin
				expRes.cr.val = {16'b0, scaledAddr(curOp.valRs[`EX_ADDR_W-1:0],
					curOp.valRt[`EX_ADDR_W-1:0], r[5:4])}; // PC comes in as Rs
			end else begin
				expRes.cr.val = {16'b0, curOp.valRs[`EX_ADDR_W-1:0]};
			end
			if (curOp.cmd == UCMD_BSR || curOp.cmd == UCMD_JSR) begin
				expRes.lrOut = curOp.pc;
			end
			runOp(1'b0, 1'b0);
		end
	endtask

	task automatic testFlagsTraps();
		exSub_t flagSubs[6] = '{SUB_CLRT, SUB_SETT, SUB_NOTT, SUB_CLRS, SUB_SETS, SUB_NOTS};
		exSub_t sysSubs[4] = '{SUB_NOP, SUB_TRAPA, SUB_RTE, SUB_SYSE};
		foreach (flagSubs[i]) begin
			prepareOp(UCMD_OP_FLAG, {2'b00, flagSubs[i]});
			case (flagSubs[i])
				SUB_CLRT: expRes.srOut[0] = 1'b0;
				SUB_SETT: expRes.srOut[0] = 1'b1;
				SUB_NOTT: expRes.srOut[0] = !curCtrl.sr[0];
				SUB_CLRS: expRes.srOut[1] = 1'b0;
				SUB_SETS: expRes.srOut[1] = 1'b1;
				default: expRes.srOut[1] = !curCtrl.sr[1];
			endcase
			runOp(1'b0, 1'b0);
		end
		foreach (sysSubs[i]) begin
			prepareOp(UCMD_OP_SYS, {2'b00, sysSubs[i]});
			case (sysSubs[i])
				SUB_TRAPA: expRes.trapCode = {`EX_TRAP_TRAPA_BASE, curOp.idRm[3:0]};
				SUB_RTE: expRes.trapCode = `EX_TRAP_RTE;
				SUB_SYSE: expRes.trapCode = {`EX_TRAP_SYSE_TAG, curCtrl.dlr[11:0]};
				default: expRes.trapCode = 16'h0000;
			endcase
			runOp(1'b0, 1'b0);
		end
	endtask

	task automatic testStickyFault();
		checkBit("haltFault", haltFault, 1'b0);
		prepareOp(UCMD_OP_SYS, {2'b00, SUB_BREAK});
		expRes.fault = 1'b1;
		runOp(1'b0, 1'b0);
		checkBit("haltFault", haltFault, 1'b1);
		for (int i = 0; i < 2; i++) begin
			prepareOp(UCMD_NOP, 8'h00);
			runOp(1'b0, 1'b0);
			checkBit("haltFault", haltFault, 1'b1);
		end
		applyReset();
		prepareOp(UCMD_OP_SYS, {2'b00, SUB_BREAK});
		curOp.cond = COND_NV; // Dropped by predication so no fault
		runOp(1'b0, 1'b0);
		checkBit("haltFault", haltFault, 1'b0);
		prepareOp(UCMD_INVOP, 8'h00);
		expRes.fault = 1'b1;
		runOp(1'b0, 1'b0);
		prepareOp(UCMD_NOP, 8'h00);
		runOp(1'b0, 1'b0);
		checkBit("haltFault", haltFault, 1'b1);
	endtask

	initial begin
		rstN = 1'b0;
		opValid = 1'b0;
		op = '0;
		ctrl = '0;
		opFlush = 1'b0;
		memBusy = 1'b0;
		applyReset();
		testRegMoves();
		testPredication();
		testMemory();
		testBranches();
		testFlagsTraps();
		testStickyFault(); // Leaves haltFault set so it runs last
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+logic
+incdir+testbench
logic/exStagePkg.sv
logic/exOpGate.sv
logic/exAddrGen.sv
logic/exOpExec.sv
logic/exResultStage.sv
logic/exStageTop.sv
testbench/exStageTb.sv

// ==== Makefile ====
TOP = exStageTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f -o simv

run: compile
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
